//--- design/cachePkg.sv
package cachePkg;

    // cache geometry, all derived from word and line sizes.
    localparam int wordWidth    = 32;
    localparam int numLines     = 16;
    localparam int wordsPerLine = 4;
    localparam int lineWidth    = wordWidth * wordsPerLine;
    localparam int offsetWidth  = $clog2(wordsPerLine);
    localparam int indexWidth   = $clog2(numLines);
    localparam int tagWidth     = wordWidth - indexWidth - offsetWidth;

    // word address split, tag on top.
    typedef struct packed {
        logic [tagWidth-1:0]    tag;
        logic [indexWidth-1:0]  index;
        logic [offsetWidth-1:0] offset;
    } addrFields_t;

    // flat view goes to memory, field view drives the lookup.
    typedef union packed {
        logic [wordWidth-1:0] flat;
        addrFields_t          fields;
    } cacheAddr_t;

endpackage

//--- design/lookupIf.sv
`timescale 1ns/100ps

interface lookupIf import cachePkg::*; ();

    logic       reqValid;
    cacheAddr_t reqAddr;

    // back-pressure from execute, freezes the decode register.
    logic       hold;

    modport decodeSide (
        output reqValid,
        output reqAddr,
        input  hold
    );

    modport coreSide (
        input  reqValid,
        input  reqAddr,
        output hold
    );

endinterface

//--- design/addrDecode.sv
`timescale 1ns/100ps

module addrDecode import cachePkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [wordWidth-1:0] a,
    input  logic                 readEnable,
    input  logic                 stall,
    lookupIf.decodeSide          lookup
);

    cacheAddr_t incoming;
    logic       accept;

    // incoming word seen as address fields.
    assign incoming.flat = a;
    assign accept        = readEnable && !stall;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            lookup.reqValid <= 1'b0;
        end else if (!lookup.hold) begin
            lookup.reqValid <= accept;
        end
    end

    // address payload loads only on an accepted request.
    always_ff @(posedge clk) begin
        if (accept) begin
            lookup.reqAddr <= incoming;
        end
    end

    // a held request must reach execute unchanged.
    holdKeepsRequest: assert property (
        @(posedge clk) disable iff (!rstN)
        lookup.hold |=> $stable(lookup.reqAddr)
    ) else $error("reqAddr changed while held");

endmodule

//--- design/cacheCore.sv
`timescale 1ns/100ps

module cacheCore import cachePkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    lookupIf.coreSide              lookup,
    input  logic [lineWidth-1:0]   memLine,
    input  logic                   memReady,
    output logic [wordWidth-1:0]   aMem,
    output logic                   memRead,
    output logic                   cacheStall,
    output logic                   hitValid,
    output logic [lineWidth-1:0]   hitLine,
    output logic [offsetWidth-1:0] hitOffset
);

    localparam logic stateIdle    = 1'b0;
    localparam logic stateWaitMem = 1'b1;

    logic [lineWidth-1:0]  dataArray [numLines];
    logic [tagWidth-1:0]   tagArray  [numLines];
    logic [numLines-1:0]   validBits;

    logic                  state;
    cacheAddr_t            missAddr;
    cacheAddr_t            alignedAddr;
    logic [indexWidth-1:0] reqIndex;
    logic                  tagMatch;
    logic                  lookupHit;
    logic                  lookupMiss;
    logic                  refill;

    assign reqIndex = lookup.reqAddr.fields.index;
    assign tagMatch = validBits[reqIndex]
                   && (tagArray[reqIndex] == lookup.reqAddr.fields.tag);

    // lookups only count while no fetch is outstanding.
    assign lookupHit  = (state == stateIdle) && lookup.reqValid && tagMatch;
    assign lookupMiss = (state == stateIdle) && lookup.reqValid && !tagMatch;
    assign refill     = (state == stateWaitMem) && memReady;

    assign cacheStall  = (state == stateWaitMem) || lookupMiss;
    assign lookup.hold = cacheStall;
    assign aMem        = missAddr.flat;

    // line-aligned copy of the request.
    always_comb begin
        alignedAddr               = lookup.reqAddr;
        alignedAddr.fields.offset = '0;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= stateIdle;
            memRead   <= 1'b0;
            validBits <= '0;
            hitValid  <= 1'b0;
        end else begin
            hitValid <= lookupHit;
            case (state)
                stateIdle: begin
                    if (lookupMiss) begin
                        state   <= stateWaitMem;
                        memRead <= 1'b1;
                    end
                end
                stateWaitMem: begin
                    if (memReady) begin
                        state                            <= stateIdle;
                        memRead                          <= 1'b0;
                        validBits[missAddr.fields.index] <= 1'b1;
                    end
                end
                default: state <= stateIdle;
            endcase
        end
    end

    // arrays and the fetch address.
    always_ff @(posedge clk) begin
        if (lookupMiss) begin
            missAddr <= alignedAddr;
        end
        if (refill) begin
            dataArray[missAddr.fields.index] <= memLine;
            tagArray[missAddr.fields.index]  <= missAddr.fields.tag;
        end
    end

    // hit payload towards result.
    always_ff @(posedge clk) begin
        if (lookupHit) begin
            hitLine   <= dataArray[reqIndex];
            hitOffset <= lookup.reqAddr.fields.offset;
        end
    end

    // requester stays held for the whole fetch.
    fetchStalls: assert property (
        @(posedge clk) disable iff (!rstN)
        memRead |-> cacheStall
    ) else $error("memRead high without cacheStall");

    // memory only answers an outstanding fetch.
    readyNeedsRead: assert property (
        @(posedge clk) disable iff (!rstN)
        memReady |-> memRead
    ) else $error("memReady sampled while memRead low");

endmodule

//--- design/wordSelect.sv
`timescale 1ns/100ps

module wordSelect import cachePkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   hitValid,
    input  logic [lineWidth-1:0]   hitLine,
    input  logic [offsetWidth-1:0] hitOffset,
    output logic [wordWidth-1:0]   value,
    output logic                   valueValid
);

    logic [wordWidth-1:0] selectedWord;

    // word 0 sits in the low bits of the line.
    assign selectedWord = hitLine[hitOffset*wordWidth +: wordWidth];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            valueValid <= 1'b0;
        end else begin
            valueValid <= hitValid;
        end
    end

    // value holds until the next hit.
    always_ff @(posedge clk) begin
        if (hitValid) begin
            value <= selectedWord;
        end
    end

endmodule

//--- design/dCache.sv
`timescale 1ns/100ps

module dCache import cachePkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [wordWidth-1:0] a,
    input  logic                 readEnable,
    input  logic [lineWidth-1:0] memLine,
    input  logic                 memReady,
    output logic [wordWidth-1:0] value,
    output logic                 valueValid,
    output logic [wordWidth-1:0] aMem,
    output logic                 memRead,
    output logic                 cacheStall
);

    logic                   hitValid;
    logic [lineWidth-1:0]   hitLine;
    logic [offsetWidth-1:0] hitOffset;

    lookupIf lookupBus ();

    addrDecode decodeStage (
        .clk        (clk),
        .rstN       (rstN),
        .a          (a),
        .readEnable (readEnable),
        .stall      (cacheStall),
        .lookup     (lookupBus.decodeSide)
    );

    cacheCore coreStage (
        .clk        (clk),
        .rstN       (rstN),
        .lookup     (lookupBus.coreSide),
        .memLine    (memLine),
        .memReady   (memReady),
        .aMem       (aMem),
        .memRead    (memRead),
        .cacheStall (cacheStall),
        .hitValid   (hitValid),
        .hitLine    (hitLine),
        .hitOffset  (hitOffset)
    );

    wordSelect resultStage (
        .clk        (clk),
        .rstN       (rstN),
        .hitValid   (hitValid),
        .hitLine    (hitLine),
        .hitOffset  (hitOffset),
        .value      (value),
        .valueValid (valueValid)
    );

endmodule

//--- test/lineMemory.sv
`timescale 1ns/100ps

module lineMemory import cachePkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 memRead,
    input  logic [wordWidth-1:0] aMem,
    output logic [lineWidth-1:0] memLine,
    output logic                 memReady
);

    integer seed;
    int     countdown;
    logic   busy;

    // word w of line L reads back as (L + w) xor 5A5A0000.
    function automatic logic [lineWidth-1:0] lineFor(input logic [wordWidth-1:0] base);
        logic [lineWidth-1:0] line;
        int                   w;
        line = '0;
        for (w = 0; w < wordsPerLine; w++) begin
            line[w*wordWidth +: wordWidth] = (base + w) ^ 32'h5A5A0000;
        end
        return line;
    endfunction

    initial begin
        seed     = 95329;
        memReady = 1'b0;
        memLine  = '0;
    end

    always @(posedge clk) begin
        if (!rstN) begin
            busy      <= 1'b0;
            countdown <= 0;
            memReady  <= 1'b0;
        end else if (!busy) begin
            if (memRead) begin
                busy      <= 1'b1;
                countdown <= 1 + ({$random(seed)} % 8);
            end
        end else if (countdown > 1) begin
            countdown <= countdown - 1;
        end else if (!memReady) begin
            memReady <= 1'b1;
            memLine  <= lineFor(aMem);
        end else begin
            // pulse sampled, fetch is over.
            memReady <= 1'b0;
            busy     <= 1'b0;
        end
    end

endmodule

//--- test/tbDCache.sv
`timescale 1ns/100ps

module tbDCache import cachePkg::*; ();

    localparam int vectorCount  = 31;
    localparam int stallTimeout = 50;
    localparam int drainTimeout = 100;

    logic                 clk = 1'b0;
    logic                 rstN;
    logic [wordWidth-1:0] a;
    logic                 readEnable;
    logic [lineWidth-1:0] memLine;
    logic                 memReady;
    logic [wordWidth-1:0] value;
    logic                 valueValid;
    logic [wordWidth-1:0] aMem;
    logic                 memRead;
    logic                 cacheStall;

    // address, expected word, hit flag per vector.
    logic [31:0] vecData [3*vectorCount];
    int          pendingIdx[$];
    int          acceptCycle [vectorCount];
    int          missCount [vectorCount];
    int          lastAccepted = 0;
    int          cycleCount = 0;
    int          doneCount = 0;
    int          headIdx;
    logic        memReadPrev = 1'b0;

    dCache i_dut (
        .clk        (clk),
        .rstN       (rstN),
        .a          (a),
        .readEnable (readEnable),
        .memLine    (memLine),
        .memReady   (memReady),
        .value      (value),
        .valueValid (valueValid),
        .aMem       (aMem),
        .memRead    (memRead),
        .cacheStall (cacheStall)
    );

    lineMemory memModel (
        .clk      (clk),
        .rstN     (rstN),
        .memRead  (memRead),
        .aMem     (aMem),
        .memLine  (memLine),
        .memReady (memReady)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task checkValue(input string what, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("Verification failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task failRun(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Verification failed");
        $fatal(1, "stopped on error");
    endtask

    // offer one request and repeat it until an edge accepts it.
    task issueRequest(input int idx);
        int waitCycles;
        int seenCycle;
        waitCycles = 0;
        a          <= vecData[3*idx];
        readEnable <= 1'b1;
        @(negedge clk);
        while (cacheStall) begin
            waitCycles++;
            if (waitCycles > stallTimeout) begin
                failRun("request held off by cacheStall for too long");
            end
            @(negedge clk);
        end
        seenCycle = cycleCount;
        @(posedge clk);
        acceptCycle[idx] = seenCycle;
        lastAccepted     = idx;
        pendingIdx.push_back(idx);
    endtask

    // fetch tracking and result checks sampled mid-cycle.
    always @(negedge clk) begin
        if (rstN) begin
            if (memRead && !memReadPrev) begin
                missCount[lastAccepted]++;
                checkValue("aMem", aMem, vecData[3*lastAccepted] & ~32'h3);
            end
            if (memRead) begin
                checkValue("cacheStall during fetch", 32'(cacheStall), 32'd1);
            end
            if (valueValid) begin
                if (pendingIdx.size() == 0) begin
                    failRun("valueValid pulsed with no request outstanding");
                end else begin
                    headIdx = pendingIdx.pop_front();
                    checkValue("value", value, vecData[3*headIdx+1]);
                    checkValue("fetch count", missCount[headIdx],
                               (vecData[3*headIdx+2] != 0) ? 32'd0 : 32'd1);
                    // a hit comes out two edges after the accepting edge.
                    if (vecData[3*headIdx+2] != 0) begin
                        checkValue("hit latency", cycleCount - acceptCycle[headIdx], 32'd3);
                    end
                    doneCount++;
                end
            end
        end
        memReadPrev = memRead;
    end

    initial begin
        int i;
        int drainCycles;
        rstN       = 1'b0;
        readEnable = 1'b0;
        a          = '0;
        for (i = 0; i < vectorCount; i++) begin
            missCount[i]   = 0;
            acceptCycle[i] = 0;
        end
        $readmemh("test/dCacheVectors.txt", vecData);
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue("memRead after reset", 32'(memRead), 32'd0);
        checkValue("cacheStall after reset", 32'(cacheStall), 32'd0);
        checkValue("valueValid after reset", 32'(valueValid), 32'd0);
        @(posedge clk);
        for (i = 0; i < vectorCount; i++) begin
            issueRequest(i);
        end
        readEnable <= 1'b0;
        drainCycles = 0;
        while (doneCount < vectorCount) begin
            @(negedge clk);
            drainCycles++;
            if (drainCycles > drainTimeout) begin
                failRun("results still missing after the last request");
            end
        end
        // pipeline is two stages deep, so any later pulse is a duplicate.
        repeat (4) @(negedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

//--- test/dCacheVectors.txt
// columns: word address, expected word, hit flag (1 hit, 0 miss)
// expected word is (aligned address + offset) xor 5A5A0000
00000010 5A5A0010 0
00000013 5A5A0013 1
00000011 5A5A0011 1
00000012 5A5A0012 1
00000050 5A5A0050 0
00000011 5A5A0011 0
00000052 5A5A0052 0
00000013 5A5A0013 0
00000024 5A5A0024 0
00000025 5A5A0025 1
00000051 5A5A0051 0
00000026 5A5A0026 1
00000012 5A5A0012 0
00000027 5A5A0027 1
00000024 5A5A0024 1
00000025 5A5A0025 1
00000026 5A5A0026 1
00000027 5A5A0027 1
00000010 5A5A0010 1
00000011 5A5A0011 1
12345678 486E5678 0
1234567A 486E567A 1
ABCDEF00 F197EF00 0
ABCDEF03 F197EF03 1
0000003C 5A5A003C 0
0000003F 5A5A003F 1
FFFFFFFC A5A5FFFC 0
FFFFFFFF A5A5FFFF 1
0000003D 5A5A003D 0
12345679 486E5679 1
00000026 5A5A0026 1

//--- sim.f
design/cachePkg.sv
design/lookupIf.sv
design/addrDecode.sv
design/cacheCore.sv
design/wordSelect.sv
design/dCache.sv
test/lineMemory.sv
test/tbDCache.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tbDCache -f sim.f \
		--Mdir obj_dir -o simDCache
	./obj_dir/simDCache | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
